// ==== hw/tcb_mon_pkg.sv ====
package tcb_mon_pkg;

    ////////////////////
    // bus widths
    ////////////////////

    // address and data buses
    localparam int unsigned ADR_W = 16;
    localparam int unsigned DAT_W = 32;

    // idle/backpressure counters, saturating
    localparam int unsigned CNT_W = 16;

    // free running timestamp, wraps
    localparam int unsigned TIM_W = 32;

    ////////////////////
    // record field types
    ////////////////////

    typedef logic [ADR_W-1:0] adr_t;
    typedef logic [DAT_W-1:0] dat_t;
    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [TIM_W-1:0] tim_t;

    ////////////////////
    // capture FSM
    ////////////////////

    // stopped after reset, overflow is sticky until start/stop
    typedef enum logic [1:0] {
        cap_stopped,
        cap_running,
        cap_overflow
    } cap_state_t;

endpackage: tcb_mon_pkg

// ==== hw/tcb_mon_cycle_counter.sv ====
module tcb_mon_cycle_counter (
    input  logic              mon,
    input  logic              reset,
    // bus handshake
    input  logic              vld,
    input  logic              rdy,
    // transfer and its snapshot
    output logic              trn,
    output tcb_mon_pkg::cnt_t idl,
    output tcb_mon_pkg::cnt_t bpr,
    output tcb_mon_pkg::tim_t tim
);

    import tcb_mon_pkg::*;

    // saturation limit of both counters
    localparam cnt_t CNT_MAX = '1;

    // transfer when both sides of the handshake agree
    assign trn = vld & rdy;

    ////////////////////
    // idle/backpressure
    ////////////////////

    // register values are the snapshot in the transfer cycle
    always_ff @(posedge mon) begin
        if (reset) begin
            idl <= '0;
            bpr <= '0;
        end else if (trn) begin
            // restart counting toward the next transfer
            idl <= '0;
            bpr <= '0;
        end else begin
            // slave ready, nothing requested
            if (rdy && !vld && idl != CNT_MAX) begin
                idl <= idl + cnt_t'(1);
            end
            // request stalled by slave
            if (vld && !rdy && bpr != CNT_MAX) begin
                bpr <= bpr + cnt_t'(1);
            end
        end
    end

    ////////////////////
    // timestamp
    ////////////////////

    // free running, wraps on overflow
    always_ff @(posedge mon) begin
        if (reset) begin
            tim <= '0;
        end else begin
            tim <= tim + tim_t'(1);
        end
    end

endmodule: tcb_mon_cycle_counter

// ==== hw/tcb_mon_rsp_align.sv ====
module tcb_mon_rsp_align #(
    // response delay in cycles, at least 1
    parameter int unsigned DLY = 2
)(
    input  logic              mon,
    input  logic              reset,
    // transfer and capture enable
    input  logic              trn,
    input  logic              capture,
    // request side
    input  logic              wen,
    input  tcb_mon_pkg::adr_t adr,
    input  tcb_mon_pkg::dat_t wdt,
    // response side, DLY cycles later
    input  tcb_mon_pkg::dat_t rdt,
    input  logic              err,
    // snapshot of the transfer cycle
    input  tcb_mon_pkg::cnt_t idl,
    input  tcb_mon_pkg::cnt_t bpr,
    input  tcb_mon_pkg::tim_t tim,
    // joined record
    output logic              rec_strobe,
    output logic              rec_wen,
    output tcb_mon_pkg::adr_t rec_adr,
    output tcb_mon_pkg::dat_t rec_wdt,
    output tcb_mon_pkg::dat_t rec_rdt,
    output logic              rec_err,
    output tcb_mon_pkg::cnt_t rec_idl,
    output tcb_mon_pkg::cnt_t rec_bpr,
    output tcb_mon_pkg::tim_t rec_tim
);

    import tcb_mon_pkg::*;

    // one entry per stage, so DLY transfers can be in flight
    logic [DLY-1:0] stg_vld;
    logic           stg_wen [DLY];
    adr_t           stg_adr [DLY];
    dat_t           stg_wdt [DLY];
    cnt_t           stg_idl [DLY];
    cnt_t           stg_bpr [DLY];
    tim_t           stg_tim [DLY];

    ////////////////////
    // delay line
    ////////////////////

    // valid bits, new entry only for captured transfers
    always_ff @(posedge mon) begin
        if (reset) begin
            stg_vld <= '0;
        end else begin
            stg_vld[0] <= trn & capture;
            for (int i = 1; i < DLY; i++) begin
                stg_vld[i] <= stg_vld[i-1];
            end
        end
    end

    // request fields and snapshot
    always_ff @(posedge mon) begin
        if (trn && capture) begin
            stg_wen[0] <= wen;
            stg_adr[0] <= adr;
            stg_wdt[0] <= wdt;
            stg_idl[0] <= idl;
            stg_bpr[0] <= bpr;
            stg_tim[0] <= tim;
        end
        // shift every cycle to keep up with back-to-back transfers
        for (int i = 1; i < DLY; i++) begin
            stg_wen[i] <= stg_wen[i-1];
            stg_adr[i] <= stg_adr[i-1];
            stg_wdt[i] <= stg_wdt[i-1];
            stg_idl[i] <= stg_idl[i-1];
            stg_bpr[i] <= stg_bpr[i-1];
            stg_tim[i] <= stg_tim[i-1];
        end
    end

    ////////////////////
    // join with response
    ////////////////////

    // last stage lines up with the current response
    assign rec_strobe = stg_vld[DLY-1];
    assign rec_wen    = stg_wen[DLY-1];
    assign rec_adr    = stg_adr[DLY-1];
    assign rec_wdt    = stg_wdt[DLY-1];
    assign rec_idl    = stg_idl[DLY-1];
    assign rec_bpr    = stg_bpr[DLY-1];
    assign rec_tim    = stg_tim[DLY-1];
    assign rec_rdt    = rdt;
    assign rec_err    = err;

endmodule: tcb_mon_rsp_align

// ==== hw/tcb_mon_record_fifo.sv ====
module tcb_mon_record_fifo #(
    // number of records, power of two
    parameter int unsigned DEPTH = 8
)(
    input  logic              mon,
    input  logic              reset,
    // strobes
    input  logic              push,
    input  logic              pop,
    // record written on push
    input  logic              in_wen,
    input  tcb_mon_pkg::adr_t in_adr,
    input  tcb_mon_pkg::dat_t in_wdt,
    input  tcb_mon_pkg::dat_t in_rdt,
    input  logic              in_err,
    input  tcb_mon_pkg::cnt_t in_idl,
    input  tcb_mon_pkg::cnt_t in_bpr,
    input  tcb_mon_pkg::tim_t in_tim,
    // levels
    output logic              full,
    output logic              empty,
    // head record, shown without delay
    output logic              rec_wen,
    output tcb_mon_pkg::adr_t rec_adr,
    output tcb_mon_pkg::dat_t rec_wdt,
    output tcb_mon_pkg::dat_t rec_rdt,
    output logic              rec_err,
    output tcb_mon_pkg::cnt_t rec_idl,
    output tcb_mon_pkg::cnt_t rec_bpr,
    output tcb_mon_pkg::tim_t rec_tim
);

    import tcb_mon_pkg::*;

    // memory address width and flat record width
    localparam int unsigned AW    = $clog2(DEPTH);
    localparam int unsigned REC_W = 1 + ADR_W + 2*DAT_W + 1 + 2*CNT_W + TIM_W;

    logic [REC_W-1:0] mem [DEPTH];
    logic [REC_W-1:0] in_rec;
    logic [REC_W-1:0] head;
    // pointers one bit wider than the address
    logic [AW:0]      wr_ptr;
    logic [AW:0]      rd_ptr;
    logic             wr_en;
    logic             rd_en;

    assign in_rec = {in_wen, in_adr, in_wdt, in_rdt, in_err, in_idl, in_bpr, in_tim};

    ////////////////////
    // levels
    ////////////////////

    // equal pointers, nothing stored
    assign empty = (wr_ptr == rd_ptr);
    // same address, wrapped once
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // pop on empty is ignored
    assign wr_en = push & ~full;
    assign rd_en = pop & ~empty;

    always_ff @(posedge mon) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge mon) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= in_rec;
        end
    end

    // fall through read of the head
    assign head = mem[rd_ptr[AW-1:0]];
    assign {rec_wen, rec_adr, rec_wdt, rec_rdt, rec_err, rec_idl, rec_bpr, rec_tim} = head;

endmodule: tcb_mon_record_fifo

// ==== hw/tcb_mon_capture_fsm.sv ====
module tcb_mon_capture_fsm (
    input  logic mon,
    input  logic reset,
    // control strobes
    input  logic start,
    input  logic stop,
    // record from the aligner, FIFO level
    input  logic rec_strobe,
    input  logic full,
    // status and control
    output logic capture,
    output logic push,
    output logic overflow
);

    import tcb_mon_pkg::*;

    cap_state_t state;
    cap_state_t state_nxt;

    ////////////////////
    // next state
    ////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            cap_stopped: begin
                if (start) begin
                    state_nxt = cap_running;
                end
            end
            cap_running: begin
                // stop wins over a dropped record
                if (stop) begin
                    state_nxt = cap_stopped;
                end else if (rec_strobe && full) begin
                    state_nxt = cap_overflow;
                end
            end
            cap_overflow: begin
                if (stop) begin
                    state_nxt = cap_stopped;
                end else if (start) begin
                    state_nxt = cap_running;
                end
            end
            default: state_nxt = cap_stopped;
        endcase
    end

    always_ff @(posedge mon) begin
        if (reset) begin
            state <= cap_stopped;
        end else begin
            state <= state_nxt;
        end
    end

    ////////////////////
    // outputs
    ////////////////////

    // new transfers enter the aligner only while running
    assign capture  = (state == cap_running);
    // in flight entries still land after stop, dropped when full
    assign push     = rec_strobe & ~full;
    // sticky until the next start or stop
    assign overflow = (state == cap_overflow);

endmodule: tcb_mon_capture_fsm

// ==== hw/tcb_mon_top.sv ====
module tcb_mon_top #(
    // response delay in cycles
    parameter int unsigned DLY   = 2,
    // FIFO records, power of two
    parameter int unsigned DEPTH = 8
)(
    input  logic              mon,
    input  logic              reset,
    // monitored bus
    input  logic              vld,
    input  logic              rdy,
    input  logic              wen,
    input  tcb_mon_pkg::adr_t adr,
    input  tcb_mon_pkg::dat_t wdt,
    input  tcb_mon_pkg::dat_t rdt,
    input  logic              err,
    // control and read side
    input  logic              start,
    input  logic              stop,
    input  logic              rec_pop,
    output logic              rec_empty,
    output logic              overflow,
    // head record
    output logic              rec_wen,
    output tcb_mon_pkg::adr_t rec_adr,
    output tcb_mon_pkg::dat_t rec_wdt,
    output tcb_mon_pkg::dat_t rec_rdt,
    output logic              rec_err,
    output tcb_mon_pkg::cnt_t rec_idl,
    output tcb_mon_pkg::cnt_t rec_bpr,
    output tcb_mon_pkg::tim_t rec_tim
);

    import tcb_mon_pkg::*;

    // transfer snapshot
    logic trn;
    cnt_t idl;
    cnt_t bpr;
    tim_t tim;

    // joined record from the aligner
    logic rec_strobe;
    logic aln_wen;
    adr_t aln_adr;
    dat_t aln_wdt;
    dat_t aln_rdt;
    logic aln_err;
    cnt_t aln_idl;
    cnt_t aln_bpr;
    tim_t aln_tim;

    // FSM/FIFO handshake
    logic capture;
    logic push;
    logic full;

    ////////////////////
    // datapath
    ////////////////////

    tcb_mon_cycle_counter cnt_i (
        .mon   (mon),
        .reset (reset),
        .vld   (vld),
        .rdy   (rdy),
        .trn   (trn),
        .idl   (idl),
        .bpr   (bpr),
        .tim   (tim)
    );

    tcb_mon_rsp_align #(
        .DLY (DLY)
    ) aln_i (
        .mon        (mon),
        .reset      (reset),
        .trn        (trn),
        .capture    (capture),
        .wen        (wen),
        .adr        (adr),
        .wdt        (wdt),
        .rdt        (rdt),
        .err        (err),
        .idl        (idl),
        .bpr        (bpr),
        .tim        (tim),
        .rec_strobe (rec_strobe),
        .rec_wen    (aln_wen),
        .rec_adr    (aln_adr),
        .rec_wdt    (aln_wdt),
        .rec_rdt    (aln_rdt),
        .rec_err    (aln_err),
        .rec_idl    (aln_idl),
        .rec_bpr    (aln_bpr),
        .rec_tim    (aln_tim)
    );

    ////////////////////
    // control and storage
    ////////////////////

    tcb_mon_capture_fsm fsm_i (
        .mon        (mon),
        .reset      (reset),
        .start      (start),
        .stop       (stop),
        .rec_strobe (rec_strobe),
        .full       (full),
        .capture    (capture),
        .push       (push),
        .overflow   (overflow)
    );

    tcb_mon_record_fifo #(
        .DEPTH (DEPTH)
    ) fifo_i (
        .mon     (mon),
        .reset   (reset),
        .push    (push),
        .pop     (rec_pop),
        .in_wen  (aln_wen),
        .in_adr  (aln_adr),
        .in_wdt  (aln_wdt),
        .in_rdt  (aln_rdt),
        .in_err  (aln_err),
        .in_idl  (aln_idl),
        .in_bpr  (aln_bpr),
        .in_tim  (aln_tim),
        .full    (full),
        .empty   (rec_empty),
        .rec_wen (rec_wen),
        .rec_adr (rec_adr),
        .rec_wdt (rec_wdt),
        .rec_rdt (rec_rdt),
        .rec_err (rec_err),
        .rec_idl (rec_idl),
        .rec_bpr (rec_bpr),
        .rec_tim (rec_tim)
    );

endmodule: tcb_mon_top

// ==== test/tcb_mon_properties.sv ====
module tcb_mon_properties #(
    // FIFO records, as in the DUT
    parameter int unsigned DEPTH = 8
)(
    input  logic mon,
    input  logic reset,
    input  logic start,
    input  logic push,
    input  logic rec_pop,
    input  logic rec_empty,
    input  logic overflow
);

    // level counter wide enough to hold DEPTH itself
    localparam int unsigned LW = $clog2(DEPTH) + 1;
    typedef logic [LW-1:0] lvl_t;

    lvl_t        level;
    logic        start_seen;
    logic        pop_ok;
    // failed assertions so far
    int unsigned fail_cnt = 0;

    ////////////////////
    // port-side model
    ////////////////////

    // pop on an empty FIFO is ignored
    assign pop_ok = rec_pop & ~rec_empty;

    always_ff @(posedge mon) begin
        if (reset) begin
            level      <= '0;
            start_seen <= 1'b0;
        end else begin
            if (push && !pop_ok) begin
                level <= level + lvl_t'(1);
            end else if (!push && pop_ok) begin
                level <= level - lvl_t'(1);
            end
            // capture possible only after this
            if (start) begin
                start_seen <= 1'b1;
            end
        end
    end

    ////////////////////
    // assertions
    ////////////////////

    // clean state in the first cycle out of reset
    assert property (@(posedge mon) $fell(reset) |-> rec_empty && !overflow)
        else begin
            $error("FIFO not empty or overflow set right after reset");
            fail_cnt++;
        end

    // overflow needs a full FIFO in the cycle before
    assert property (@(posedge mon) disable iff (reset)
        $rose(overflow) |-> $past(level) == lvl_t'(DEPTH))
        else begin
            $error("overflow rose while the FIFO was not full");
            fail_cnt++;
        end

    // nothing recorded without a start
    assert property (@(posedge mon) disable iff (reset) !start_seen |-> rec_empty)
        else begin
            $error("record appeared before any start strobe");
            fail_cnt++;
        end

endmodule: tcb_mon_properties

// attach to the monitor top level
bind tcb_mon_top tcb_mon_properties #(
    .DEPTH (DEPTH)
) props_i (
    .mon       (mon),
    .reset     (reset),
    .start     (start),
    .push      (push),
    .rec_pop   (rec_pop),
    .rec_empty (rec_empty),
    .overflow  (overflow)
);

// ==== test/tcb_mon_tb.sv ====
module tcb_mon_tb;

    import tcb_mon_pkg::*;

    localparam int DLY   = 2;
    localparam int DEPTH = 8;
    // well above the few hundred cycles the tests take
    localparam int TIMEOUT = 2000;

    logic mon;
    logic reset;
    logic vld;
    logic rdy;
    logic wen;
    adr_t adr;
    dat_t wdt;
    dat_t rdt;
    logic err;
    logic start;
    logic stop;
    logic rec_pop;
    logic rec_empty;
    logic overflow;
    logic rec_wen;
    adr_t rec_adr;
    dat_t rec_wdt;
    dat_t rec_rdt;
    logic rec_err;
    cnt_t rec_idl;
    cnt_t rec_bpr;
    tim_t rec_tim;

    // expected record with the cycle its response is due
    typedef struct packed {
        logic wen;
        adr_t adr;
        dat_t wdt;
        dat_t rdt;
        logic err;
        cnt_t idl;
        cnt_t bpr;
        tim_t tim;
        tim_t due;
    } exp_rec_t;

    exp_rec_t pend[$];
    exp_rec_t exp_q[$];
    tim_t     cyc;
    cnt_t     m_idl;
    cnt_t     m_bpr;
    int       m_cnt;
    logic     m_cap;
    logic     m_ovf;
    logic     have_tim;
    tim_t     last_tim;
    tim_t     last_exp_tim;
    integer   seed;
    int       errors = 0;
    int       checks = 0;
    int       tests = 0;
    int       cycles = 0;

    tcb_mon_top #(
        .DLY   (DLY),
        .DEPTH (DEPTH)
    ) dut_i (.*);

    always #50 mon = ~mon;

    // watchdog
    always @(posedge mon) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, the run did not complete", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////
    // reference model
    ////////////////////

    // evaluates the cycle that ends at this edge
    always @(posedge mon) begin
        exp_rec_t r;
        logic     pushed;
        logic     dropped;
        logic     popped;
        if (reset) begin
            cyc   = '0;
            m_idl = '0;
            m_bpr = '0;
            m_cnt = 0;
            m_cap = 1'b0;
            m_ovf = 1'b0;
            pend.delete();
            exp_q.delete();
        end else begin
            pushed  = 1'b0;
            dropped = 1'b0;
            popped  = rec_pop && (m_cnt != 0);
            if (vld && rdy) begin
                // snapshot taken before the counters clear
                if (m_cap) begin
                    r     = '0;
                    r.wen = wen;
                    r.adr = adr;
                    r.wdt = wdt;
                    r.idl = m_idl;
                    r.bpr = m_bpr;
                    r.tim = cyc;
                    r.due = cyc + tim_t'(DLY);
                    pend.push_back(r);
                end
                m_idl = '0;
                m_bpr = '0;
            end else begin
                if (rdy && !vld && m_idl != '1) begin
                    m_idl = m_idl + cnt_t'(1);
                end
                if (vld && !rdy && m_bpr != '1) begin
                    m_bpr = m_bpr + cnt_t'(1);
                end
            end
            // join a due response and offer the record to the FIFO
            if (pend.size() != 0 && pend[0].due == cyc) begin
                r     = pend.pop_front();
                r.rdt = rdt;
                r.err = err;
                if (m_cnt < DEPTH) begin
                    exp_q.push_back(r);
                    pushed = 1'b1;
                end else begin
                    dropped = 1'b1;
                end
            end
            if (pushed) begin
                m_cnt++;
            end
            if (popped) begin
                m_cnt--;
            end
            // stop beats a drop in the capture state
            if (m_cap) begin
                if (stop) begin
                    m_cap = 1'b0;
                end else if (dropped) begin
                    m_cap = 1'b0;
                    m_ovf = 1'b1;
                end
            end else if (m_ovf) begin
                if (stop) begin
                    m_ovf = 1'b0;
                end else if (start) begin
                    m_ovf = 1'b0;
                    m_cap = 1'b1;
                end
            end else if (start) begin
                m_cap = 1'b1;
            end
            cyc = cyc + tim_t'(1);
        end
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        assert (got == want) else begin
            $display("error: %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    // levels follow the model every cycle
    always @(negedge mon) begin
        if (!reset) begin
            compare_field("overflow", 32'(overflow), 32'(m_ovf));
            compare_field("rec_empty", 32'(rec_empty), 32'(m_cnt == 0));
        end
    end

    ////////////////////
    // stimulus helpers
    ////////////////////

    task automatic bus_cycle(input logic v, input logic r, input logic go, input logic halt);
        logic [31:0] rnd;
        @(posedge mon);
        rnd = $random(seed);
        vld   <= v;
        rdy   <= r;
        start <= go;
        stop  <= halt;
        wen   <= rnd[0];
        err   <= rnd[1];
        adr   <= rnd[31:16];
        wdt   <= $random(seed);
        rdt   <= $random(seed);
    endtask

    // slave ready without a request
    task automatic idle(input int n);
        repeat (n) bus_cycle(1'b0, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic verify_head();
        exp_rec_t e;
        checks++;
        assert (exp_q.size() != 0) else begin
            $display("error: the FIFO shows a record that no transfer should have made");
            errors++;
        end
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            compare_field("rec_wen", 32'(rec_wen), 32'(e.wen));
            compare_field("rec_adr", 32'(rec_adr), 32'(e.adr));
            compare_field("rec_wdt", rec_wdt, e.wdt);
            compare_field("rec_rdt", rec_rdt, e.rdt);
            compare_field("rec_err", 32'(rec_err), 32'(e.err));
            compare_field("rec_idl", 32'(rec_idl), 32'(e.idl));
            compare_field("rec_bpr", 32'(rec_bpr), 32'(e.bpr));
            // time step between consecutive records
            if (have_tim) begin
                compare_field("rec_tim step", rec_tim - last_tim, e.tim - last_exp_tim);
            end
            have_tim     = 1'b1;
            last_tim     = rec_tim;
            last_exp_tim = e.tim;
        end
    endtask

    // pop until nothing is in flight, expected or shown by the FIFO
    task automatic drain_records(output int pops);
        pops = 0;
        @(negedge mon);
        while (pend.size() != 0 || exp_q.size() != 0 || !rec_empty) begin
            if (!rec_empty) begin
                verify_head();
                pops++;
                @(posedge mon);
                rec_pop <= 1'b1;
                @(posedge mon);
                rec_pop <= 1'b0;
            end
            @(negedge mon);
        end
    endtask

    task automatic expect_pops(input int got, input int want);
        checks++;
        assert (got == want) else begin
            $display("wrong number of records drained, %0d instead of %0d", got, want);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    initial begin
        int          e0;
        int          pops;
        logic [31:0] rnd;
        seed     = 32'h96cb7a30;
        mon      = 1'b0;
        reset    = 1'b1;
        vld      = 1'b0;
        rdy      = 1'b0;
        wen      = 1'b0;
        adr      = '0;
        wdt      = '0;
        rdt      = '0;
        err      = 1'b0;
        start    = 1'b0;
        stop     = 1'b0;
        rec_pop  = 1'b0;
        have_tim = 1'b0;
        repeat (10) @(posedge mon);
        reset <= 1'b0;

        // transfers before any start
        e0 = errors;
        repeat (4) bus_cycle(1'b1, 1'b1, 1'b0, 1'b0);
        bus_cycle(1'b1, 1'b0, 1'b0, 1'b0);
        bus_cycle(1'b1, 1'b1, 1'b0, 1'b0);
        idle(DLY + 2);
        drain_records(pops);
        expect_pops(pops, 0);
        report_test("reset_gating", e0);

        // back to back transfers with DLY in flight
        e0 = errors;
        bus_cycle(1'b0, 1'b1, 1'b1, 1'b0);
        repeat (6) bus_cycle(1'b1, 1'b1, 1'b0, 1'b0);
        bus_cycle(1'b0, 1'b1, 1'b0, 1'b1);
        idle(DLY + 1);
        drain_records(pops);
        expect_pops(pops, 6);
        report_test("contents_order", e0);

        // idle and back-pressure gaps of random length
        e0 = errors;
        bus_cycle(1'b0, 1'b1, 1'b1, 1'b0);
        for (int k = 0; k < 6; k++) begin
            rnd = $random(seed);
            idle(int'(rnd[1:0]) + 1);
            repeat (int'(rnd[3:2])) bus_cycle(1'b1, 1'b0, 1'b0, 1'b0);
            // neither counter moves here
            bus_cycle(1'b0, 1'b0, 1'b0, 1'b0);
            bus_cycle(1'b1, 1'b1, 1'b0, 1'b0);
        end
        bus_cycle(1'b0, 1'b1, 1'b0, 1'b1);
        idle(DLY + 1);
        drain_records(pops);
        expect_pops(pops, 6);
        report_test("counts_time", e0);

        // last transfer right before the stop strobe
        e0 = errors;
        bus_cycle(1'b0, 1'b1, 1'b1, 1'b0);
        repeat (3) bus_cycle(1'b1, 1'b1, 1'b0, 1'b0);
        bus_cycle(1'b0, 1'b1, 1'b0, 1'b1);
        repeat (3) bus_cycle(1'b1, 1'b1, 1'b0, 1'b0);
        idle(DLY + 1);
        drain_records(pops);
        expect_pops(pops, 3);
        report_test("stop", e0);

        // fill past DEPTH without pops
        e0 = errors;
        bus_cycle(1'b0, 1'b1, 1'b1, 1'b0);
        repeat (DEPTH + 3) bus_cycle(1'b1, 1'b1, 1'b0, 1'b0);
        idle(DLY + 2);
        @(negedge mon);
        compare_field("overflow", 32'(overflow), 32'd1);
        bus_cycle(1'b0, 1'b1, 1'b1, 1'b0);
        idle(1);
        @(negedge mon);
        compare_field("overflow", 32'(overflow), 32'd0);
        drain_records(pops);
        expect_pops(pops, DEPTH);
        bus_cycle(1'b1, 1'b1, 1'b0, 1'b0);
        bus_cycle(1'b0, 1'b1, 1'b0, 1'b1);
        idle(DLY + 1);
        drain_records(pops);
        expect_pops(pops, 1);
        report_test("overflow", e0);

        // failures from the bound assertions
        errors = errors + int'(dut_i.props_i.fail_cnt);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule: tcb_mon_tb

// ==== src.f ====
hw/tcb_mon_pkg.sv
hw/tcb_mon_cycle_counter.sv
hw/tcb_mon_rsp_align.sv
hw/tcb_mon_record_fifo.sv
hw/tcb_mon_capture_fsm.sv
hw/tcb_mon_top.sv
test/tcb_mon_properties.sv
test/tcb_mon_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the monitor testbench with Verilator
set -e -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tcb_mon_tb -f src.f

# keep running past assertion failures so the testbench can report them
./obj_dir/Vtcb_mon_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
